//--- rtl/cnt_pkg.sv
`default_nettype none

package cnt_pkg;

    typedef logic [7:0]  cnt_addr_t;
    typedef logic [15:0] cnt_word_t;

    typedef struct packed {
        logic      we;
        cnt_addr_t addr;
        cnt_word_t data;
    } cnt_req_t;

    typedef struct packed {
        logic      wr;
        logic      rd;
        cnt_addr_t addr;
        cnt_word_t data;
    } host_req_t;

    typedef enum logic [1:0] {
        grp_silencer,
        grp_pulse_width,
        grp_sync
    } settings_group_e;

    typedef struct packed {
        logic            valid;
        settings_group_e group;
        logic [2:0]      idx;
        logic            last;
        cnt_word_t       data;
    } rd_word_t;

    typedef enum logic {
        fixed_completion_steps = 1'b0,
        fixed_update_rate      = 1'b1
    } silencer_mode_e;

    typedef enum logic [3:0] {
        st_idle,
        st_ver_minor,
        st_ver_major,
        st_poll_rd,
        st_poll_wait,
        st_poll_eval,
        st_load_rd,
        st_load_wait0,
        st_load_wait1,
        st_write_back
    } seq_state_e;

    typedef struct packed {
        logic           update;
        silencer_mode_e mode;
        logic [15:0]    update_rate_intensity;
        logic [15:0]    update_rate_phase;
        logic [15:0]    completion_steps_intensity;
        logic [15:0]    completion_steps_phase;
    } silencer_settings_t;

    typedef struct packed {
        logic        update;
        logic [15:0] full_width_start;
    } pulse_width_settings_t;

    typedef struct packed {
        logic        update;
        logic [63:0] ecat_sync_time;
        logic [31:0] ecat_sync_base_cnt;
    } sync_settings_t;

    // status word written back to the host every poll.
    typedef struct packed {
        logic [11:0] reserved;
        logic        stm_cycle_zero;
        logic        stm_segment;
        logic        mod_segment;
        logic        thermo;
    } fpga_state_t;

    localparam cnt_addr_t ADDR_CTL_FLAG         = 8'h00;
    localparam cnt_addr_t ADDR_FPGA_STATE       = 8'h01;
    localparam cnt_addr_t ADDR_VERSION_MINOR    = 8'h02;
    localparam cnt_addr_t ADDR_VERSION_MAJOR    = 8'h03;
    localparam cnt_addr_t ADDR_SILENCER_BASE    = 8'h40;
    localparam cnt_addr_t ADDR_PULSE_WIDTH_BASE = 8'h50;
    localparam cnt_addr_t ADDR_SYNC_BASE        = 8'h60;

    localparam int SILENCER_WORDS    = 5;
    localparam int PULSE_WIDTH_WORDS = 1;
    localparam int SYNC_WORDS        = 6;

    localparam int unsigned CTL_BIT_SILENCER_SET    = 0;
    localparam int unsigned CTL_BIT_PULSE_WIDTH_SET = 1;
    localparam int unsigned CTL_BIT_SYNC_SET        = 2;
    localparam int unsigned CTL_BIT_FORCE_FAN       = 4;
    localparam int unsigned CTL_BIT_GPIO_IN_0       = 8;

    localparam silencer_settings_t SILENCER_DEFAULTS = '{
        update: 1'b0,
        mode: fixed_completion_steps,
        update_rate_intensity: 16'd256,
        update_rate_phase: 16'd256,
        completion_steps_intensity: 16'd10,
        completion_steps_phase: 16'd40
    };

    localparam pulse_width_settings_t PULSE_WIDTH_DEFAULTS = '{
        update: 1'b0,
        full_width_start: 16'd65025
    };

    localparam sync_settings_t SYNC_DEFAULTS = '{
        update: 1'b0,
        ecat_sync_time: 64'd0,
        ecat_sync_base_cnt: 32'd10240
    };

    function automatic cnt_addr_t group_base(settings_group_e grp);
        case (grp)
            grp_pulse_width: return ADDR_PULSE_WIDTH_BASE;
            grp_sync:        return ADDR_SYNC_BASE;
            default:         return ADDR_SILENCER_BASE;
        endcase
    endfunction

    function automatic logic [2:0] group_words(settings_group_e grp);
        case (grp)
            grp_pulse_width: return 3'(PULSE_WIDTH_WORDS);
            grp_sync:        return 3'(SYNC_WORDS);
            default:         return 3'(SILENCER_WORDS);
        endcase
    endfunction

    // mask of the set flag that belongs to a group.
    function automatic cnt_word_t group_flag(settings_group_e grp);
        case (grp)
            grp_pulse_width: return cnt_word_t'(1) << CTL_BIT_PULSE_WIDTH_SET;
            grp_sync:        return cnt_word_t'(1) << CTL_BIT_SYNC_SET;
            default:         return cnt_word_t'(1) << CTL_BIT_SILENCER_SET;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- rtl/cnt_ram.sv
`timescale 1ns/1ps
`default_nettype none

module cnt_ram
    import cnt_pkg::*;
(
    input  logic      CLK,
    input  host_req_t host_req,
    output cnt_word_t host_rdata,
    input  cnt_req_t  ctl_req,
    output cnt_word_t ctl_rdata
);

    cnt_word_t mem [256];

    cnt_addr_t host_addr_q;
    cnt_addr_t ctl_addr_q;

    // the controller write comes last so it wins a same-address collision.
    always_ff @(posedge CLK) begin
        if (host_req.wr) begin
            mem[host_req.addr] <= host_req.data;
        end
        if (ctl_req.we) begin
            mem[ctl_req.addr] <= ctl_req.data;
        end
    end

    // registered address and registered output give two cycles of read latency.
    always_ff @(posedge CLK) begin
        if (host_req.rd) begin
            host_addr_q <= host_req.addr;
        end
        host_rdata <= mem[host_addr_q];
    end

    always_ff @(posedge CLK) begin
        ctl_addr_q <= ctl_req.addr;
        ctl_rdata  <= mem[ctl_addr_q];
    end

endmodule

`default_nettype wire

//--- rtl/ctl_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ctl_sequencer
    import cnt_pkg::*;
#(
    parameter logic [7:0] VERSION_MAJOR = 8'h00,
    parameter logic [7:0] VERSION_MINOR = 8'h00
) (
    input  logic      CLK,
    input  logic      rst_n,
    input  logic      thermo,
    input  logic      mod_segment,
    input  logic      stm_segment,
    input  cnt_word_t stm_cycle,
    output cnt_req_t  ctl_req,
    input  cnt_word_t ctl_rdata,
    output rd_word_t  rd_word,
    output logic      force_fan,
    output logic [3:0] gpio_in
);

    typedef struct packed {
        logic            valid;
        settings_group_e group;
        logic [2:0]      idx;
        logic            last;
    } rd_tag_t;

    seq_state_e      state;
    cnt_word_t       ctl_flags;
    settings_group_e load_grp;
    logic [2:0]      load_idx;
    logic [2:0]      next_idx;
    logic            load_last;
    rd_tag_t         req_tag;
    rd_tag_t         tag_d1;
    rd_tag_t         tag_d2;
    fpga_state_t     status;
    logic            set_pending;
    settings_group_e set_grp;

    always_comb begin
        status                = '0;
        status.thermo         = thermo;
        status.mod_segment    = mod_segment;
        status.stm_segment    = stm_segment;
        status.stm_cycle_zero = (stm_cycle == '0);
    end

    // priority among the set flags is silencer, then pulse width, then sync.
    always_comb begin
        set_pending = 1'b1;
        set_grp     = grp_silencer;
        if (ctl_rdata[CTL_BIT_SILENCER_SET]) begin
            set_grp = grp_silencer;
        end else if (ctl_rdata[CTL_BIT_PULSE_WIDTH_SET]) begin
            set_grp = grp_pulse_width;
        end else if (ctl_rdata[CTL_BIT_SYNC_SET]) begin
            set_grp = grp_sync;
        end else begin
            set_pending = 1'b0;
        end
    end

    assign next_idx  = load_idx + 3'd1;
    assign load_last = (load_idx == group_words(load_grp) - 3'd1);

    // ctl_req and req_tag are loaded together with the state they belong to.
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state     <= st_idle;
            ctl_req   <= '0;
            req_tag   <= '0;
            ctl_flags <= '0;
            load_grp  <= grp_silencer;
            load_idx  <= '0;
        end else begin
            ctl_req <= '0;
            req_tag <= '0;
            case (state)
                st_idle: begin
                    ctl_req <= '{we: 1'b1, addr: ADDR_VERSION_MINOR, data: {8'h00, VERSION_MINOR}};
                    state   <= st_ver_minor;
                end
                st_ver_minor: begin
                    ctl_req <= '{we: 1'b1, addr: ADDR_VERSION_MAJOR, data: {8'h00, VERSION_MAJOR}};
                    state   <= st_ver_major;
                end
                st_ver_major, st_write_back: begin
                    ctl_req <= '{we: 1'b0, addr: ADDR_CTL_FLAG, data: '0};
                    state   <= st_poll_rd;
                end
                st_poll_rd: begin
                    state <= st_poll_wait;
                end
                st_poll_wait: begin
                    ctl_req <= '{we: 1'b1, addr: ADDR_FPGA_STATE, data: cnt_word_t'(status)};
                    state   <= st_poll_eval;
                end
                st_poll_eval: begin
                    if (set_pending) begin
                        ctl_flags <= ctl_rdata & ~group_flag(set_grp);
                        load_grp  <= set_grp;
                        load_idx  <= '0;
                        ctl_req   <= '{we: 1'b0, addr: group_base(set_grp), data: '0};
                        req_tag   <= '{valid: 1'b1, group: set_grp, idx: 3'd0,
                                       last: (group_words(set_grp) == 3'd1)};
                        state     <= st_load_rd;
                    end else begin
                        ctl_flags <= ctl_rdata;
                        ctl_req   <= '{we: 1'b0, addr: ADDR_CTL_FLAG, data: '0};
                        state     <= st_poll_rd;
                    end
                end
                st_load_rd: begin
                    if (load_last) begin
                        state <= st_load_wait0;
                    end else begin
                        load_idx <= next_idx;
                        ctl_req  <= '{we: 1'b0, addr: group_base(load_grp) + cnt_addr_t'(next_idx),
                                      data: '0};
                        req_tag  <= '{valid: 1'b1, group: load_grp, idx: next_idx,
                                      last: (next_idx == group_words(load_grp) - 3'd1)};
                    end
                end
                st_load_wait0: begin
                    state <= st_load_wait1;
                end
                st_load_wait1: begin
                    // the last word is on ctl_rdata now, so the flag copy can go back.
                    ctl_req <= '{we: 1'b1, addr: ADDR_CTL_FLAG, data: ctl_flags};
                    state   <= st_write_back;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // tags follow the RAM's two cycles of read latency.
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            tag_d1 <= '0;
            tag_d2 <= '0;
        end else begin
            tag_d1 <= req_tag;
            tag_d2 <= tag_d1;
        end
    end

    assign rd_word = '{valid: tag_d2.valid, group: tag_d2.group, idx: tag_d2.idx,
                       last: tag_d2.last, data: ctl_rdata};

    assign force_fan = ctl_flags[CTL_BIT_FORCE_FAN];
    assign gpio_in   = ctl_flags[CTL_BIT_GPIO_IN_0 +: 4];

endmodule

`default_nettype wire

//--- rtl/settings_regs.sv
`timescale 1ns/1ps
`default_nettype none

module settings_regs
    import cnt_pkg::*;
(
    input  logic                  CLK,
    input  logic                  rst_n,
    input  rd_word_t              rd_word,
    output silencer_settings_t    silencer_settings,
    output pulse_width_settings_t pulse_width_settings,
    output sync_settings_t        sync_settings
);

    logic sil_word;
    logic pw_word;
    logic sync_word;

    assign sil_word  = rd_word.valid && (rd_word.group == grp_silencer);
    assign pw_word   = rd_word.valid && (rd_word.group == grp_pulse_width);
    assign sync_word = rd_word.valid && (rd_word.group == grp_sync);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            silencer_settings    <= SILENCER_DEFAULTS;
            pulse_width_settings <= PULSE_WIDTH_DEFAULTS;
            sync_settings        <= SYNC_DEFAULTS;
        end else begin
            // update pulses once, the cycle after the last word of the group.
            silencer_settings.update    <= sil_word && rd_word.last;
            pulse_width_settings.update <= pw_word && rd_word.last;
            sync_settings.update        <= sync_word && rd_word.last;

            if (sil_word) begin
                case (rd_word.idx)
                    3'd0: silencer_settings.mode <= silencer_mode_e'(rd_word.data[0]);
                    3'd1: silencer_settings.update_rate_intensity <= rd_word.data;
                    3'd2: silencer_settings.update_rate_phase <= rd_word.data;
                    3'd3: silencer_settings.completion_steps_intensity <= rd_word.data;
                    3'd4: silencer_settings.completion_steps_phase <= rd_word.data;
                    default: ;
                endcase
            end

            if (pw_word) begin
                pulse_width_settings.full_width_start <= rd_word.data;
            end

            // sync time words come first, least significant word first.
            if (sync_word) begin
                case (rd_word.idx)
                    3'd0: sync_settings.ecat_sync_time[15:0] <= rd_word.data;
                    3'd1: sync_settings.ecat_sync_time[31:16] <= rd_word.data;
                    3'd2: sync_settings.ecat_sync_time[47:32] <= rd_word.data;
                    3'd3: sync_settings.ecat_sync_time[63:48] <= rd_word.data;
                    3'd4: sync_settings.ecat_sync_base_cnt[15:0] <= rd_word.data;
                    3'd5: sync_settings.ecat_sync_base_cnt[31:16] <= rd_word.data;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/controller_top.sv
`timescale 1ns/1ps
`default_nettype none

module controller_top
    import cnt_pkg::*;
#(
    parameter logic [7:0] VERSION_MAJOR = 8'h8c,
    parameter logic [7:0] VERSION_MINOR = 8'h01
) (
    input  logic                  CLK,
    input  logic                  rst_n,
    input  host_req_t             host_req,
    output cnt_word_t             host_rdata,
    input  logic                  thermo,
    input  logic                  mod_segment,
    input  logic                  stm_segment,
    input  cnt_word_t             stm_cycle,
    output silencer_settings_t    silencer_settings,
    output pulse_width_settings_t pulse_width_settings,
    output sync_settings_t        sync_settings,
    output logic                  force_fan,
    output logic [3:0]            gpio_in
);

    cnt_req_t  ctl_req;
    cnt_word_t ctl_rdata;
    rd_word_t  rd_word;

    cnt_ram cnt_ram_i (
        .CLK        (CLK),
        .host_req   (host_req),
        .host_rdata (host_rdata),
        .ctl_req    (ctl_req),
        .ctl_rdata  (ctl_rdata)
    );

    ctl_sequencer #(
        .VERSION_MAJOR (VERSION_MAJOR),
        .VERSION_MINOR (VERSION_MINOR)
    ) ctl_sequencer_i (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .thermo      (thermo),
        .mod_segment (mod_segment),
        .stm_segment (stm_segment),
        .stm_cycle   (stm_cycle),
        .ctl_req     (ctl_req),
        .ctl_rdata   (ctl_rdata),
        .rd_word     (rd_word),
        .force_fan   (force_fan),
        .gpio_in     (gpio_in)
    );

    settings_regs settings_regs_i (
        .CLK                  (CLK),
        .rst_n                (rst_n),
        .rd_word              (rd_word),
        .silencer_settings    (silencer_settings),
        .pulse_width_settings (pulse_width_settings),
        .sync_settings        (sync_settings)
    );

endmodule

`default_nettype wire

//--- verif/controller_tb.sv
`timescale 1ns/1ps
`default_nettype none

module controller_tb
    import cnt_pkg::*;
();

    localparam logic [7:0] VERSION_MAJOR = 8'h8c;
    localparam logic [7:0] VERSION_MINOR = 8'h01;
    localparam int PULSE_TIMEOUT = 200;

    logic                  CLK = 1'b0;
    logic                  rst_n;
    host_req_t             host_req;
    cnt_word_t             host_rdata;
    logic                  thermo;
    logic                  mod_segment;
    logic                  stm_segment;
    cnt_word_t             stm_cycle;
    silencer_settings_t    silencer_settings;
    pulse_width_settings_t pulse_width_settings;
    sync_settings_t        sync_settings;
    logic                  force_fan;
    logic [3:0]            gpio_in;

    integer          seed = 32'hf882_f444;
    int              errors = 0;
    int              checks = 0;
    int              tests = 0;
    int              errors_at_start;
    string           test_name;
    cnt_word_t [5:0] sil_w;
    cnt_word_t [5:0] pw_w;
    cnt_word_t [5:0] sync_w;
    settings_group_e pulse_q[$];

    always #2 CLK = ~CLK;

    controller_top #(
        .VERSION_MAJOR (VERSION_MAJOR),
        .VERSION_MINOR (VERSION_MINOR)
    ) controller_top_i (
        .CLK                  (CLK),
        .rst_n                (rst_n),
        .host_req             (host_req),
        .host_rdata           (host_rdata),
        .thermo               (thermo),
        .mod_segment          (mod_segment),
        .stm_segment          (stm_segment),
        .stm_cycle            (stm_cycle),
        .silencer_settings    (silencer_settings),
        .pulse_width_settings (pulse_width_settings),
        .sync_settings        (sync_settings),
        .force_fan            (force_fan),
        .gpio_in              (gpio_in)
    );

    // records update pulses in the order they occur.
    always @(negedge CLK) begin
        if (silencer_settings.update) begin
            pulse_q.push_back(grp_silencer);
        end
        if (pulse_width_settings.update) begin
            pulse_q.push_back(grp_pulse_width);
        end
        if (sync_settings.update) begin
            pulse_q.push_back(grp_sync);
        end
    end

    // expected settings from the words at the group base, in struct field order.
    function automatic silencer_settings_t expected_silencer(input cnt_word_t [5:0] w,
                                                             input logic upd);
        silencer_settings_t s;
        s.update                     = upd;
        s.mode                       = silencer_mode_e'(w[0][0]);
        s.update_rate_intensity      = w[1];
        s.update_rate_phase          = w[2];
        s.completion_steps_intensity = w[3];
        s.completion_steps_phase     = w[4];
        return s;
    endfunction

    function automatic pulse_width_settings_t expected_pulse_width(input cnt_word_t [5:0] w,
                                                                   input logic upd);
        return '{update: upd, full_width_start: w[0]};
    endfunction

    // sync time and base count both arrive least significant word first.
    function automatic sync_settings_t expected_sync(input cnt_word_t [5:0] w, input logic upd);
        return '{update: upd, ecat_sync_time: {w[3], w[2], w[1], w[0]},
                 ecat_sync_base_cnt: {w[5], w[4]}};
    endfunction

    function automatic logic update_bit_of(input settings_group_e grp);
        case (grp)
            grp_silencer:    return silencer_settings.update;
            grp_pulse_width: return pulse_width_settings.update;
            default:         return sync_settings.update;
        endcase
    endfunction

    task automatic compare_silencer(input string what, input silencer_settings_t got,
                                    input silencer_settings_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0d ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_pulse_width(input string what, input pulse_width_settings_t got,
                                       input pulse_width_settings_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0d ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_sync(input string what, input sync_settings_t got,
                                input sync_settings_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0d ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_word(input string what, input cnt_word_t got, input cnt_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0d ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    task automatic host_write(input cnt_addr_t address, input cnt_word_t data);
        @(posedge CLK);
        host_req <= '{wr: 1'b1, rd: 1'b0, addr: address, data: data};
        @(posedge CLK);
        host_req <= '0;
    endtask

    // read data is valid two cycles after the edge that takes the strobe.
    task automatic host_read(input cnt_addr_t address, output cnt_word_t data);
        @(posedge CLK);
        host_req <= '{wr: 1'b0, rd: 1'b1, addr: address, data: '0};
        @(posedge CLK);
        host_req <= '0;
        @(posedge CLK);
        @(negedge CLK);
        data = host_rdata;
    endtask

    task automatic wait_update(input settings_group_e grp, output logic seen);
        int cycles;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < PULSE_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
            seen = update_bit_of(grp);
        end
        if (!seen) begin
            errors++;
            $display("timeout: no %s update pulse within %0d cycles", grp.name(), PULSE_TIMEOUT);
        end
    endtask

    task automatic fill_group(input settings_group_e grp, input cnt_addr_t base, input int n);
        cnt_word_t [5:0] w;
        int i;
        w = '0;
        for (i = 0; i < n; i++) begin
            w[i] = 16'($random(seed));
            host_write(base + 8'(i), w[i]);
        end
        case (grp)
            grp_silencer:    sil_w = w;
            grp_pulse_width: pw_w = w;
            default:         sync_w = w;
        endcase
    endtask

    task automatic verify_group(input settings_group_e grp, input logic upd);
        case (grp)
            grp_silencer: begin
                compare_silencer("silencer settings", silencer_settings,
                                 expected_silencer(sil_w, upd));
            end
            grp_pulse_width: begin
                compare_pulse_width("pulse width settings", pulse_width_settings,
                                    expected_pulse_width(pw_w, upd));
            end
            default: begin
                compare_sync("sync settings", sync_settings, expected_sync(sync_w, upd));
            end
        endcase
    endtask

    task automatic load_group(input settings_group_e grp, input cnt_addr_t base, input int n,
                              input cnt_word_t set_bit);
        cnt_word_t flags;
        cnt_word_t rd;
        logic      seen;
        fill_group(grp, base, n);
        // keep the other set flags clear so only this group loads.
        flags = (16'($random(seed)) & 16'hfff8) | set_bit;
        host_write(ADDR_CTL_FLAG, flags);
        wait_update(grp, seen);
        if (seen) begin
            verify_group(grp, 1'b1);
            @(negedge CLK);
            compare_word("update bit one cycle later", {15'd0, update_bit_of(grp)}, 16'd0);
        end
        host_read(ADDR_CTL_FLAG, rd);
        compare_word("flag word after load", rd, flags & ~set_bit);
    endtask

    initial begin
        cnt_word_t rd;
        cnt_word_t flags;
        logic      fan;
        logic [3:0] gpio;
        int        i;
        int        cycles;

        rst_n       <= 1'b0;
        host_req    <= '0;
        thermo      <= 1'b0;
        mod_segment <= 1'b0;
        stm_segment <= 1'b0;
        stm_cycle   <= '0;
        repeat (4) @(posedge CLK);
        rst_n <= 1'b1;

        begin_test("reset and startup");
        @(negedge CLK);
        compare_silencer("silencer defaults", silencer_settings,
                         '{update: 1'b0, mode: fixed_completion_steps,
                           update_rate_intensity: 16'd256, update_rate_phase: 16'd256,
                           completion_steps_intensity: 16'd10, completion_steps_phase: 16'd40});
        compare_pulse_width("pulse width defaults", pulse_width_settings,
                            '{update: 1'b0, full_width_start: 16'd65025});
        compare_sync("sync defaults", sync_settings,
                     '{update: 1'b0, ecat_sync_time: 64'd0, ecat_sync_base_cnt: 32'd10240});
        compare_word("fan and gpio after reset", {11'd0, force_fan, gpio_in}, 16'd0);
        repeat (8) @(posedge CLK);
        host_read(ADDR_VERSION_MINOR, rd);
        compare_word("version minor", rd, {8'h00, VERSION_MINOR});
        host_read(ADDR_VERSION_MAJOR, rd);
        compare_word("version major", rd, {8'h00, VERSION_MAJOR});
        end_test();

        begin_test("status reporting");
        for (i = 0; i < 3; i++) begin
            @(posedge CLK);
            thermo      <= 1'($random(seed));
            mod_segment <= 1'($random(seed));
            stm_segment <= 1'($random(seed));
            stm_cycle   <= (i == 0) ? 16'd0 : 16'($random(seed));
            // longer than one 3-cycle poll period.
            repeat (8) @(posedge CLK);
            host_read(ADDR_FPGA_STATE, rd);
            compare_word("status word", rd,
                         {12'd0, stm_cycle == 16'd0, stm_segment, mod_segment, thermo});
        end
        end_test();

        begin_test("silencer load");
        load_group(grp_silencer, ADDR_SILENCER_BASE, 5, cnt_word_t'(1) << CTL_BIT_SILENCER_SET);
        end_test();

        begin_test("pulse width load");
        load_group(grp_pulse_width, ADDR_PULSE_WIDTH_BASE, 1,
                   cnt_word_t'(1) << CTL_BIT_PULSE_WIDTH_SET);
        end_test();

        begin_test("sync load");
        load_group(grp_sync, ADDR_SYNC_BASE, 6, cnt_word_t'(1) << CTL_BIT_SYNC_SET);
        end_test();

        begin_test("priority with fan and gpio");
        fill_group(grp_silencer, ADDR_SILENCER_BASE, 5);
        fill_group(grp_pulse_width, ADDR_PULSE_WIDTH_BASE, 1);
        fill_group(grp_sync, ADDR_SYNC_BASE, 6);
        fan   = 1'($random(seed));
        gpio  = 4'($random(seed));
        flags = 16'h0007 | ({15'd0, fan} << CTL_BIT_FORCE_FAN) |
                ({12'd0, gpio} << CTL_BIT_GPIO_IN_0);
        pulse_q.delete();
        host_write(ADDR_CTL_FLAG, flags);
        cycles = 0;
        while (pulse_q.size() < 3 && cycles < 3 * PULSE_TIMEOUT) begin
            @(posedge CLK);
            cycles++;
        end
        if (pulse_q.size() < 3) begin
            errors++;
            $display("timeout: only %0d of 3 update pulses within %0d cycles",
                     pulse_q.size(), 3 * PULSE_TIMEOUT);
        end else begin
            compare_word("update pulse order", {10'd0, pulse_q[0], pulse_q[1], pulse_q[2]},
                         {10'd0, grp_silencer, grp_pulse_width, grp_sync});
        end
        @(negedge CLK);
        verify_group(grp_silencer, 1'b0);
        verify_group(grp_pulse_width, 1'b0);
        verify_group(grp_sync, 1'b0);
        host_read(ADDR_CTL_FLAG, rd);
        compare_word("flag word after all loads", rd, flags & ~16'h0007);
        compare_word("force_fan and gpio_in", {11'd0, force_fan, gpio_in}, {11'd0, fan, gpio});
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
rtl/cnt_pkg.sv
rtl/cnt_ram.sv
rtl/ctl_sequencer.sv
rtl/settings_regs.sv
rtl/controller_top.sv
verif/controller_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module controller_tb -f filelist.f -o controller_sim

out=$(./obj_dir/controller_sim)
echo "$out"

# the run counts as passed only if the pass line shows up in the output
echo "$out" | grep -q "^Result: PASSED$"
